//--- hw/cc_consts.svh
// ------------------------------------------------------------------------
// Core complex constants: bus widths, offload target count, SSR
// configuration register file shape and data route FIFO depth
// ------------------------------------------------------------------------

`ifndef CC_CONSTS_SVH
`define CC_CONSTS_SVH

// Data bus
`define CC_ADDR_WIDTH 32
`define CC_DATA_WIDTH 32

// Offload interface
`define CC_ID_WIDTH 5
`define CC_NUM_TARGETS 3
`define CC_TARGET_SSR 2

// SSR configuration space, data movers by registers
`define CC_SSR_NUM_DM 2
`define CC_SSR_NUM_REGS 8

// Data routing
`define CC_TCDM_ADDR_WIDTH 17
`define CC_ROUTE_DEPTH 4

`endif

//--- hw/cc_pkg.sv
// ------------------------------------------------------------------------
// Core complex types: vector typedefs, offload operation and slot state
// enums, offload and data port request/response structs
// ------------------------------------------------------------------------

`include "cc_consts.svh"

package cc_pkg;

  // Plain vectors
  typedef logic [`CC_ADDR_WIDTH-1:0]           addr_t;
  typedef logic [`CC_DATA_WIDTH-1:0]           data_t;
  typedef logic [`CC_DATA_WIDTH/8-1:0]         strb_t;
  typedef logic [`CC_ID_WIDTH-1:0]             acc_id_t;
  typedef logic [$clog2(`CC_NUM_TARGETS)-1:0]  target_t;
  // Bits 4:0 data mover, bits 11:5 register
  typedef logic [11:0]                         cfg_word_t;

  // SSR configuration operations
  typedef enum logic [1:0] {
    OP_SCFGR  = 2'd0,
    OP_SCFGW  = 2'd1,
    OP_SCFGRI = 2'd2,
    OP_SCFGWI = 2'd3
  } acc_op_e;

  // Offload request and response
  typedef struct packed {
    target_t   target;
    acc_id_t   id;
    acc_op_e   op;
    cfg_word_t imm;
    data_t     arga;
    data_t     argb;
  } acc_req_t;

  typedef struct packed {
    acc_id_t id;
    logic    error;
    data_t   data;
  } acc_rsp_t;

  // Data port request and response
  typedef struct packed {
    addr_t addr;
    logic  write;
    data_t wdata;
    strb_t strb;
  } dreq_t;

  typedef struct packed {
    data_t rdata;
    logic  error;
  } drsp_t;

  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_FULL  = 1'b1
  } slot_state_e;

endpackage

//--- hw/offload_switch.sv
// ------------------------------------------------------------------------
// Offload switch: request demux by target index and round-robin
// response arbiter into a one-entry output register
// ------------------------------------------------------------------------

`include "cc_consts.svh"

module offload_switch (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // Core request
  input  cc_pkg::acc_req_t                         core_req_i,
  input  logic                                     core_q_valid_i,
  output logic                                     core_q_ready_o,
  // Core response
  output cc_pkg::acc_rsp_t                         core_rsp_o,
  output logic                                     core_p_valid_o,
  input  logic                                     core_p_ready_i,
  // Target request handshake, payload is shared
  output logic             [`CC_NUM_TARGETS-1:0]   tgt_q_valid_o,
  input  logic             [`CC_NUM_TARGETS-1:0]   tgt_q_ready_i,
  // Target responses
  input  cc_pkg::acc_rsp_t [`CC_NUM_TARGETS-1:0]   tgt_rsp_i,
  input  logic             [`CC_NUM_TARGETS-1:0]   tgt_p_valid_i,
  output logic             [`CC_NUM_TARGETS-1:0]   tgt_p_ready_o
);

  import cc_pkg::*;

  localparam int unsigned NumTargets = `CC_NUM_TARGETS;

  // Round-robin state and grant
  target_t  rr_q;
  target_t  gnt_idx;
  logic     gnt_found;

  // Output register
  acc_rsp_t rsp_q;
  logic     rsp_valid_q;
  logic     rsp_load;

  // ------------------------------------------------------------------------
  // Request demux
  // ------------------------------------------------------------------------

  // Unknown target index falls through with ready high and is dropped
  always_comb begin
    tgt_q_valid_o  = '0;
    core_q_ready_o = 1'b1;
    for (int unsigned i = 0; i < NumTargets; i++) begin
      if (core_req_i.target == target_t'(i)) begin
        tgt_q_valid_o[i] = core_q_valid_i;
        core_q_ready_o   = tgt_q_ready_i[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Response arbiter
  // ------------------------------------------------------------------------

  // Search starts at the pointer and wraps around
  always_comb begin
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = '0;
    cand      = 0;
    for (int unsigned i = 0; i < NumTargets; i++) begin
      cand = (int'(rr_q) + i) % NumTargets;
      if (!gnt_found && tgt_p_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = target_t'(cand);
      end
    end
  end

  // Register takes a new entry when empty or draining this cycle
  assign rsp_load = !rsp_valid_q || core_p_ready_i;

  always_comb begin
    tgt_p_ready_o = '0;
    if (rsp_load && gnt_found) begin
      tgt_p_ready_o[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      rsp_valid_q <= 1'b0;
      rsp_q       <= '0;
      rr_q        <= '0;
    end else if (rsp_load) begin
      rsp_valid_q <= gnt_found;
      if (gnt_found) begin
        rsp_q <= tgt_rsp_i[gnt_idx];
        // Next search begins just after the winner
        if (gnt_idx == target_t'(NumTargets - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= gnt_idx + 1'b1;
        end
      end
    end
  end

  assign core_rsp_o     = rsp_q;
  assign core_p_valid_o = rsp_valid_q;

endmodule

//--- hw/ssr_cfg_unit.sv
// ------------------------------------------------------------------------
// SSR configuration unit: operation decode, configuration register
// file and one-entry response slot
// ------------------------------------------------------------------------

`include "cc_consts.svh"

module ssr_cfg_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Offload request
  input  cc_pkg::acc_req_t req_i,
  input  logic             q_valid_i,
  output logic             q_ready_o,
  // Offload response
  output cc_pkg::acc_rsp_t rsp_o,
  output logic             p_valid_o,
  input  logic             p_ready_i
);

  import cc_pkg::*;

  localparam int unsigned NumDm   = `CC_SSR_NUM_DM;
  localparam int unsigned NumRegs = `CC_SSR_NUM_REGS;
  localparam int unsigned NumCfg  = NumDm * NumRegs;
  localparam int unsigned IdxW    = $clog2(NumCfg);

  // Decode
  cfg_word_t       word;
  logic [4:0]      dm_sel;
  logic [6:0]      reg_sel;
  logic            in_range;
  logic            is_write;
  logic [IdxW-1:0] cfg_idx;
  data_t           rdata;
  logic            accept;

  // State
  data_t [NumCfg-1:0] cfg_q;
  slot_state_e        slot_q;
  acc_rsp_t           rsp_q;

  // ------------------------------------------------------------------------
  // Operation decode
  // ------------------------------------------------------------------------

  // Immediate forms carry the word index in the instruction
  assign word = (req_i.op == OP_SCFGRI || req_i.op == OP_SCFGWI) ? req_i.imm
                                                                  : req_i.argb[11:0];
  assign is_write = (req_i.op == OP_SCFGW) || (req_i.op == OP_SCFGWI);

  assign dm_sel   = word[4:0];
  assign reg_sel  = word[11:5];
  assign in_range = (int'(dm_sel) < NumDm) && (int'(reg_sel) < NumRegs);
  assign cfg_idx  = IdxW'(int'(dm_sel) * NumRegs + int'(reg_sel));

  // Old value, zero outside the register file
  assign rdata = in_range ? cfg_q[cfg_idx] : '0;

  // ------------------------------------------------------------------------
  // Register file and response slot
  // ------------------------------------------------------------------------

  assign q_ready_o = (slot_q == SLOT_EMPTY) || p_ready_i;
  assign accept    = q_valid_i && q_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      slot_q <= SLOT_EMPTY;
      rsp_q  <= '0;
      cfg_q  <= '0;
    end else begin
      if (accept) begin
        slot_q      <= SLOT_FULL;
        // Writes return id 0 so the core skips the write-back
        rsp_q.id    <= is_write ? acc_id_t'(0) : req_i.id;
        rsp_q.error <= 1'b0;
        rsp_q.data  <= rdata;
        if (is_write && in_range) begin
          cfg_q[cfg_idx] <= req_i.arga;
        end
      end else if (p_ready_i) begin
        slot_q <= SLOT_EMPTY;
      end
    end
  end

  assign rsp_o     = rsp_q;
  assign p_valid_o = (slot_q == SLOT_FULL);

endmodule

//--- hw/data_router.sv
// ------------------------------------------------------------------------
// Data router: TCDM window decode, request steering to TCDM or SoC
// and in-order response return through a route FIFO
// ------------------------------------------------------------------------

`include "cc_consts.svh"

module data_router (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  cc_pkg::addr_t tcdm_base_i,
  // Core data port
  input  cc_pkg::dreq_t core_req_i,
  input  logic          core_q_valid_i,
  output logic          core_q_ready_o,
  output cc_pkg::drsp_t core_rsp_o,
  output logic          core_p_valid_o,
  input  logic          core_p_ready_i,
  // SoC port
  output cc_pkg::dreq_t soc_req_o,
  output logic          soc_q_valid_o,
  input  logic          soc_q_ready_i,
  input  cc_pkg::drsp_t soc_rsp_i,
  input  logic          soc_p_valid_i,
  output logic          soc_p_ready_o,
  // TCDM port
  output cc_pkg::dreq_t tcdm_req_o,
  output logic          tcdm_q_valid_o,
  input  logic          tcdm_q_ready_i,
  input  cc_pkg::drsp_t tcdm_rsp_i,
  input  logic          tcdm_p_valid_i,
  output logic          tcdm_p_ready_o
);

  import cc_pkg::*;

  localparam int unsigned Depth = `CC_ROUTE_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam addr_t WinMask = {`CC_ADDR_WIDTH{1'b1}} << `CC_TCDM_ADDR_WIDTH;

  logic               to_tcdm;
  logic               push;
  logic               pop;
  logic               full;
  logic               empty;
  logic               head;
  // One bit per outstanding request, high for TCDM
  logic [Depth-1:0]   route_q;
  logic [PtrW-1:0]    wr_ptr_q;
  logic [PtrW-1:0]    rd_ptr_q;
  logic [PtrW:0]      count_q;

  // Window test on the high address bits
  assign to_tcdm = (core_req_i.addr & WinMask) == (tcdm_base_i & WinMask);

  // Request steering, stalled while the route FIFO is full
  assign full           = (count_q == (PtrW + 1)'(Depth));
  assign soc_req_o      = core_req_i;
  assign tcdm_req_o     = core_req_i;
  assign soc_q_valid_o  = core_q_valid_i && !full && !to_tcdm;
  assign tcdm_q_valid_o = core_q_valid_i && !full && to_tcdm;
  assign core_q_ready_o = !full && (to_tcdm ? tcdm_q_ready_i : soc_q_ready_i);
  assign push           = core_q_valid_i && core_q_ready_o;

  // Response return from the port at the FIFO head only
  assign empty          = (count_q == '0);
  assign head           = route_q[rd_ptr_q];
  assign core_rsp_o     = head ? tcdm_rsp_i : soc_rsp_i;
  assign core_p_valid_o = !empty && (head ? tcdm_p_valid_i : soc_p_valid_i);
  assign soc_p_ready_o  = !empty && !head && core_p_ready_i;
  assign tcdm_p_ready_o = !empty && head && core_p_ready_i;
  assign pop            = core_p_valid_o && core_p_ready_i;

  // ------------------------------------------------------------------------
  // Route FIFO
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_ni) begin
      route_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        route_q[wr_ptr_q] <= to_tcdm;
        wr_ptr_q          <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

//--- hw/core_complex_top.sv
// ------------------------------------------------------------------------
// Core complex fabric top: offload switch, SSR configuration unit
// and data router
// ------------------------------------------------------------------------

`include "cc_consts.svh"

module core_complex_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  cc_pkg::addr_t                          tcdm_base_i,
  // Core offload port
  input  cc_pkg::acc_req_t                       core_req_i,
  input  logic                                   core_q_valid_i,
  output logic                                   core_q_ready_o,
  output cc_pkg::acc_rsp_t                       core_rsp_o,
  output logic                                   core_p_valid_o,
  input  logic                                   core_p_ready_i,
  // Core data port
  input  cc_pkg::dreq_t                          data_req_i,
  input  logic                                   data_q_valid_i,
  output logic                                   data_q_ready_o,
  output cc_pkg::drsp_t                          data_rsp_o,
  output logic                                   data_p_valid_o,
  input  logic                                   data_p_ready_i,
  // External accelerators, 0 is the FPU and 1 the shared muldiv
  output cc_pkg::acc_req_t [`CC_TARGET_SSR-1:0]  acc_req_o,
  output logic             [`CC_TARGET_SSR-1:0]  acc_q_valid_o,
  input  logic             [`CC_TARGET_SSR-1:0]  acc_q_ready_i,
  input  cc_pkg::acc_rsp_t [`CC_TARGET_SSR-1:0]  acc_rsp_i,
  input  logic             [`CC_TARGET_SSR-1:0]  acc_p_valid_i,
  output logic             [`CC_TARGET_SSR-1:0]  acc_p_ready_o,
  // SoC memory port
  output cc_pkg::dreq_t                          soc_req_o,
  output logic                                   soc_q_valid_o,
  input  logic                                   soc_q_ready_i,
  input  cc_pkg::drsp_t                          soc_rsp_i,
  input  logic                                   soc_p_valid_i,
  output logic                                   soc_p_ready_o,
  // TCDM port
  output cc_pkg::dreq_t                          tcdm_req_o,
  output logic                                   tcdm_q_valid_o,
  input  logic                                   tcdm_q_ready_i,
  input  cc_pkg::drsp_t                          tcdm_rsp_i,
  input  logic                                   tcdm_p_valid_i,
  output logic                                   tcdm_p_ready_o
);

  import cc_pkg::*;

  // Target side of the switch, SSR unit sits above the external ports
  logic     [`CC_NUM_TARGETS-1:0] tgt_q_valid;
  logic     [`CC_NUM_TARGETS-1:0] tgt_q_ready;
  acc_rsp_t [`CC_NUM_TARGETS-1:0] tgt_rsp;
  logic     [`CC_NUM_TARGETS-1:0] tgt_p_valid;
  logic     [`CC_NUM_TARGETS-1:0] tgt_p_ready;

  // Request payload is shared by all targets
  assign acc_req_o     = {`CC_TARGET_SSR{core_req_i}};
  assign acc_q_valid_o = tgt_q_valid[`CC_TARGET_SSR-1:0];
  assign acc_p_ready_o = tgt_p_ready[`CC_TARGET_SSR-1:0];

  assign tgt_q_ready[`CC_TARGET_SSR-1:0] = acc_q_ready_i;
  assign tgt_rsp[`CC_TARGET_SSR-1:0]     = acc_rsp_i;
  assign tgt_p_valid[`CC_TARGET_SSR-1:0] = acc_p_valid_i;

  offload_switch i_offload_switch (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .core_req_i     (core_req_i),
    .core_q_valid_i (core_q_valid_i),
    .core_q_ready_o (core_q_ready_o),
    .core_rsp_o     (core_rsp_o),
    .core_p_valid_o (core_p_valid_o),
    .core_p_ready_i (core_p_ready_i),
    .tgt_q_valid_o  (tgt_q_valid),
    .tgt_q_ready_i  (tgt_q_ready),
    .tgt_rsp_i      (tgt_rsp),
    .tgt_p_valid_i  (tgt_p_valid),
    .tgt_p_ready_o  (tgt_p_ready)
  );

  ssr_cfg_unit i_ssr_cfg_unit (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (core_req_i),
    .q_valid_i (tgt_q_valid[`CC_TARGET_SSR]),
    .q_ready_o (tgt_q_ready[`CC_TARGET_SSR]),
    .rsp_o     (tgt_rsp[`CC_TARGET_SSR]),
    .p_valid_o (tgt_p_valid[`CC_TARGET_SSR]),
    .p_ready_i (tgt_p_ready[`CC_TARGET_SSR])
  );

  data_router i_data_router (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .tcdm_base_i    (tcdm_base_i),
    .core_req_i     (data_req_i),
    .core_q_valid_i (data_q_valid_i),
    .core_q_ready_o (data_q_ready_o),
    .core_rsp_o     (data_rsp_o),
    .core_p_valid_o (data_p_valid_o),
    .core_p_ready_i (data_p_ready_i),
    .soc_req_o      (soc_req_o),
    .soc_q_valid_o  (soc_q_valid_o),
    .soc_q_ready_i  (soc_q_ready_i),
    .soc_rsp_i      (soc_rsp_i),
    .soc_p_valid_i  (soc_p_valid_i),
    .soc_p_ready_o  (soc_p_ready_o),
    .tcdm_req_o     (tcdm_req_o),
    .tcdm_q_valid_o (tcdm_q_valid_o),
    .tcdm_q_ready_i (tcdm_q_ready_i),
    .tcdm_rsp_i     (tcdm_rsp_i),
    .tcdm_p_valid_i (tcdm_p_valid_i),
    .tcdm_p_ready_o (tcdm_p_ready_o)
  );

endmodule

//--- bench/cc_checker.sv
// ------------------------------------------------------------------------
// Handshake assertions on the core complex top level, bound into the DUT
// ------------------------------------------------------------------------

module cc_checker (
  input logic             clk_i,
  input logic             rst_ni,
  input cc_pkg::acc_rsp_t core_rsp_o,
  input logic             core_p_valid_o,
  input logic             core_p_ready_i,
  input cc_pkg::drsp_t    data_rsp_o,
  input logic             data_p_valid_o,
  input logic             data_p_ready_i,
  input cc_pkg::dreq_t    soc_req_o,
  input logic             soc_q_valid_o,
  input logic             soc_q_ready_i,
  input cc_pkg::dreq_t    tcdm_req_o,
  input logic             tcdm_q_valid_o,
  input logic             tcdm_q_ready_i,
  input logic [1:0]       acc_q_valid_o
);

  // Offload response holds under back-pressure
  a_core_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
    core_p_valid_o && !core_p_ready_i |=> core_p_valid_o && $stable(core_rsp_o))
    else $error("core offload response changed while stalled");

  // Data ports
  a_data_rsp_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
    data_p_valid_o && !data_p_ready_i |=> data_p_valid_o && $stable(data_rsp_o))
    else $error("core data response changed while stalled");

  a_soc_req_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
    soc_q_valid_o && !soc_q_ready_i |=> soc_q_valid_o && $stable(soc_req_o))
    else $error("SoC request changed while stalled");

  a_tcdm_req_hold: assert property (@(posedge clk_i) disable iff (rst_ni)
    tcdm_q_valid_o && !tcdm_q_ready_i |=> tcdm_q_valid_o && $stable(tcdm_req_o))
    else $error("TCDM request changed while stalled");

  // Quiet outputs once reset has been seen on an edge
  a_reset_quiet: assert property (@(posedge clk_i)
    $past(rst_ni) && rst_ni |-> !core_p_valid_o && !data_p_valid_o && !soc_q_valid_o
      && !tcdm_q_valid_o && (acc_q_valid_o == 2'b00))
    else $error("valid output high during reset");

endmodule

bind core_complex_top cc_checker i_cc_checker (.*);

//--- bench/cc_tb.sv
// ------------------------------------------------------------------------
// Core complex testbench with accelerator and memory models, scoreboards
// and directed tests for offload routing, SSR configuration and data routing
// ------------------------------------------------------------------------

`include "cc_consts.svh"

// Accelerator model answering with arga plus its target index
module acc_model #(parameter int unsigned Idx = 0) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  cc_pkg::acc_req_t req_i,
  input  logic             q_valid_i,
  output logic             q_ready_o,
  output cc_pkg::acc_rsp_t rsp_o,
  output logic             p_valid_o,
  input  logic             p_ready_i
);
  import cc_pkg::*;
  acc_rsp_t pend_q[$];
  acc_rsp_t rsp;
  logic     q_fire;
  logic     p_fire;

  initial begin
    q_ready_o = 1'b0;
    p_valid_o = 1'b0;
    rsp_o     = '0;
  end

  always begin
    @(negedge clk_i);
    q_fire = q_valid_i && q_ready_o;
    p_fire = p_valid_o && p_ready_i;
    if (q_fire) begin
      rsp       = '0;
      rsp.id    = req_i.id;
      rsp.data  = req_i.arga + data_t'(Idx);
      pend_q.push_back(rsp);
    end
    @(posedge clk_i);
    #10;
    if (rst_ni) begin
      q_ready_o = 1'b0;
      p_valid_o = 1'b0;
    end else begin
      q_ready_o = ($urandom % 4) != 0;
      if (p_fire) begin
        p_valid_o = 1'b0;
      end
      // Random delay before the next response
      if (!p_valid_o && pend_q.size() > 0 && ($urandom % 3) == 0) begin
        rsp_o     = pend_q.pop_front();
        p_valid_o = 1'b1;
      end
    end
  end
endmodule

// Memory model with random ready and in-order responses
module mem_model #(parameter logic [31:0] Salt = 32'h0) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  cc_pkg::dreq_t req_i,
  input  logic          q_valid_i,
  output logic          q_ready_o,
  output cc_pkg::drsp_t rsp_o,
  output logic          p_valid_o,
  input  logic          p_ready_i
);
  import cc_pkg::*;
  data_t mem [1024];
  drsp_t pend_q[$];
  drsp_t rsp;
  logic  q_fire;
  logic  p_fire;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (32'(i) * 32'h9E37_79B9) ^ Salt;
    end
    q_ready_o = 1'b0;
    p_valid_o = 1'b0;
    rsp_o     = '0;
  end

  always begin
    @(negedge clk_i);
    q_fire = q_valid_i && q_ready_o;
    p_fire = p_valid_o && p_ready_i;
    if (q_fire) begin
      rsp = '0;
      if (req_i.write) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.strb[b]) mem[req_i.addr[11:2]][8*b +: 8] = req_i.wdata[8*b +: 8];
        end
      end else begin
        rsp.rdata = mem[req_i.addr[11:2]];
      end
      pend_q.push_back(rsp);
    end
    @(posedge clk_i);
    #10;
    if (rst_ni) begin
      q_ready_o = 1'b0;
      p_valid_o = 1'b0;
    end else begin
      q_ready_o = ($urandom % 3) != 0;
      if (p_fire) begin
        p_valid_o = 1'b0;
      end
      if (!p_valid_o && pend_q.size() > 0 && ($urandom % 4) == 0) begin
        rsp_o     = pend_q.pop_front();
        p_valid_o = 1'b1;
      end
    end
  end
endmodule

module cc_tb;
  import cc_pkg::*;

  localparam int unsigned NumTxn   = 60;
  localparam addr_t       TcdmBase = 32'h1000_0000;
  localparam logic [31:0] SaltTcdm = 32'h5A5A_5A5A;

  logic     clk_i;
  logic     rst_ni;
  addr_t    tcdm_base_i;
  acc_req_t core_req_i;
  logic     core_q_valid_i;
  logic     core_q_ready_o;
  acc_rsp_t core_rsp_o;
  logic     core_p_valid_o;
  logic     core_p_ready_i;
  dreq_t    data_req_i;
  logic     data_q_valid_i;
  logic     data_q_ready_o;
  drsp_t    data_rsp_o;
  logic     data_p_valid_o;
  logic     data_p_ready_i;
  acc_req_t [1:0] acc_req_o;
  logic     [1:0] acc_q_valid_o;
  wire      [1:0] acc_q_ready_i;
  wire acc_rsp_t [1:0] acc_rsp_i;
  wire      [1:0] acc_p_valid_i;
  logic     [1:0] acc_p_ready_o;
  dreq_t    soc_req_o;
  logic     soc_q_valid_o;
  wire      soc_q_ready_i;
  wire drsp_t soc_rsp_i;
  wire      soc_p_valid_i;
  logic     soc_p_ready_o;
  dreq_t    tcdm_req_o;
  logic     tcdm_q_valid_o;
  wire      tcdm_q_ready_i;
  wire drsp_t tcdm_rsp_i;
  wire      tcdm_p_valid_i;
  logic     tcdm_p_ready_o;

  // Scoreboards
  int unsigned checks;
  int unsigned errors;
  logic        rand_ready;
  data_t       exp_data [32][$];
  int          outstanding;
  data_t       cfg_model [2][8];
  data_t       shadow [2][1024];
  data_t       exp_rdata[$];

  core_complex_top uut (.*);

  for (genvar t = 0; t < 2; t++) begin : g_acc
    acc_model #(.Idx(t)) i_acc (
      .clk_i, .rst_ni,
      .req_i     (acc_req_o[t]),
      .q_valid_i (acc_q_valid_o[t]),
      .q_ready_o (acc_q_ready_i[t]),
      .rsp_o     (acc_rsp_i[t]),
      .p_valid_o (acc_p_valid_i[t]),
      .p_ready_i (acc_p_ready_o[t])
    );
  end

  mem_model #(.Salt(32'h0)) i_soc_mem (
    .clk_i, .rst_ni, .req_i(soc_req_o), .q_valid_i(soc_q_valid_o), .q_ready_o(soc_q_ready_i),
    .rsp_o(soc_rsp_i), .p_valid_o(soc_p_valid_i), .p_ready_i(soc_p_ready_o)
  );

  mem_model #(.Salt(SaltTcdm)) i_tcdm_mem (
    .clk_i, .rst_ni, .req_i(tcdm_req_o), .q_valid_i(tcdm_q_valid_o),
    .q_ready_o(tcdm_q_ready_i), .rsp_o(tcdm_rsp_i), .p_valid_o(tcdm_p_valid_i),
    .p_ready_i(tcdm_p_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    repeat (NumTxn * 200 + 16) @(posedge clk_i);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  // Core side ready goes random during stress tests
  always @(posedge clk_i) begin
    #10;
    core_p_ready_i = rand_ready ? 1'($urandom % 2) : 1'b1;
    data_p_ready_i = rand_ready ? 1'($urandom % 2) : 1'b1;
  end

  task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] got);
    checks++;
    if (exp !== got) begin
      $display("Fail %s: expected %0h, got %0h", name, exp, got);
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Response monitors
  // ------------------------------------------------------------------------

  always @(negedge clk_i) begin
    if (!rst_ni && core_p_valid_o && core_p_ready_i) begin
      if (exp_data[core_rsp_o.id].size() == 0) begin
        $display("Offload response with id %0d was not expected", core_rsp_o.id);
        errors++;
      end else begin
        check_val("core_rsp_o.data", exp_data[core_rsp_o.id].pop_front(), core_rsp_o.data);
        check_val("core_rsp_o.error", 0, core_rsp_o.error);
        outstanding--;
      end
    end
    if (!rst_ni && data_p_valid_o && data_p_ready_i) begin
      if (exp_rdata.size() == 0) begin
        $display("Data response arrived with no request outstanding");
        errors++;
      end else begin
        check_val("data_rsp_o.rdata", exp_rdata.pop_front(), data_rsp_o.rdata);
        check_val("data_rsp_o.error", 0, data_rsp_o.error);
      end
    end
  end

  // ------------------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------------------

  task automatic send_offload(input acc_req_t req, input acc_id_t rsp_id, input data_t exp);
    logic       fired;
    logic [1:0] exp_valid;
    exp_valid = (req.target < 2) ? (2'b01 << req.target) : 2'b00;
    if (req.target <= 2) begin
      exp_data[rsp_id].push_back(exp);
      outstanding++;
    end
    core_req_i     = req;
    core_q_valid_i = 1'b1;
    fired          = 1'b0;
    while (!fired) begin
      @(negedge clk_i);
      check_val("acc_q_valid_o", exp_valid, acc_q_valid_o);
      if (req.target < 2) begin
        check_val("acc_req_o", req, acc_req_o[req.target[0]]);
      end
      fired = core_q_ready_o;
      @(posedge clk_i);
      #10;
    end
    core_q_valid_i = 1'b0;
  endtask

  task automatic accel_op(input target_t tgt, input acc_id_t id, input data_t arga);
    acc_req_t req;
    req        = '0;
    req.target = tgt;
    req.id     = id;
    req.arga   = arga;
    req.argb   = ~arga;
    send_offload(req, id, arga + data_t'(tgt));
  endtask

  // Old value comes back; out-of-range words read 0 and ignore writes
  task automatic ssr_op(input acc_op_e op, input cfg_word_t word, input data_t arga,
                        input acc_id_t id);
    acc_req_t req;
    logic     wr;
    logic     hit;
    data_t    old;
    wr  = (op == OP_SCFGW) || (op == OP_SCFGWI);
    hit = (word[4:0] < 5'd2) && (word[11:5] < 7'd8);
    old = hit ? cfg_model[word[0]][word[7:5]] : '0;
    if (wr && hit) cfg_model[word[0]][word[7:5]] = arga;
    req        = '0;
    req.target = 2'd2;
    req.id     = id;
    req.op     = op;
    req.arga   = arga;
    if (op == OP_SCFGRI || op == OP_SCFGWI) req.imm = word;
    else req.argb = {20'hABCDE, word};
    send_offload(req, wr ? acc_id_t'(0) : id, old);
  endtask

  task automatic data_op(input logic wr, input addr_t addr, input data_t wdata);
    logic        to_tcdm;
    logic        fired;
    int unsigned idx;
    to_tcdm = (addr >> `CC_TCDM_ADDR_WIDTH) == (TcdmBase >> `CC_TCDM_ADDR_WIDTH);
    idx     = addr[11:2];
    if (wr) begin
      shadow[to_tcdm][idx] = wdata;
      exp_rdata.push_back('0);
    end else begin
      exp_rdata.push_back(shadow[to_tcdm][idx]);
    end
    data_req_i       = '0;
    data_req_i.addr  = addr;
    data_req_i.write = wr;
    data_req_i.wdata = wdata;
    data_req_i.strb  = 4'hF;
    data_q_valid_i   = 1'b1;
    fired            = 1'b0;
    while (!fired) begin
      @(negedge clk_i);
      fired = data_q_ready_o;
      if (fired) begin
        check_val("tcdm_q_valid_o", to_tcdm, tcdm_q_valid_o);
        check_val("soc_q_valid_o", !to_tcdm, soc_q_valid_o);
        check_val("port req addr", addr, to_tcdm ? tcdm_req_o.addr : soc_req_o.addr);
      end
      @(posedge clk_i);
      #10;
    end
    data_q_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    int unsigned n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while ((outstanding != 0 || exp_rdata.size() != 0) && n < 2000);
    #10;
    if (outstanding != 0 || exp_rdata.size() != 0) begin
      $display("Responses missing: %0d offload, %0d data", outstanding, exp_rdata.size());
      errors++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------------

  task automatic test_reset_quiet();
    check_val("core_p_valid_o", 0, core_p_valid_o);
    check_val("acc_q_valid_o", 0, acc_q_valid_o);
    check_val("soc_q_valid_o", 0, soc_q_valid_o);
    check_val("tcdm_q_valid_o", 0, tcdm_q_valid_o);
    check_val("data_p_valid_o", 0, data_p_valid_o);
  endtask

  task automatic test_accel_routing();
    accel_op(2'd0, 5'd1, 32'h1000_0000);
    accel_op(2'd1, 5'd2, 32'h2000_0000);
    accel_op(2'd0, 5'd3, 32'hFFFF_FFFF);
    accel_op(2'd1, 5'd4, 32'h0000_1234);
    // Unknown target is accepted and dropped
    accel_op(2'd3, 5'd5, 32'h0BAD_0BAD);
    wait_idle();
  endtask

  task automatic test_ssr_config();
    ssr_op(OP_SCFGW, {7'd3, 5'd1}, 32'hCAFE_0001, 5'd5);
    ssr_op(OP_SCFGWI, {7'd6, 5'd0}, 32'hBEEF_0002, 5'd6);
    ssr_op(OP_SCFGR, {7'd3, 5'd1}, 32'h0, 5'd7);
    ssr_op(OP_SCFGRI, {7'd6, 5'd0}, 32'h0, 5'd8);
    ssr_op(OP_SCFGWI, {7'd2, 5'd4}, 32'hDEAD_0003, 5'd9);
    ssr_op(OP_SCFGRI, {7'd2, 5'd4}, 32'h0, 5'd10);
    ssr_op(OP_SCFGR, {7'd9, 5'd0}, 32'h0, 5'd11);
    wait_idle();
  endtask

  task automatic test_offload_stress();
    target_t tgt;
    rand_ready = 1'b1;
    for (int i = 1; i <= 30; i++) begin
      tgt = target_t'($urandom % 3);
      if (tgt == 2'd2) begin
        ssr_op(OP_SCFGRI, {4'd0, 3'($urandom), 4'd0, 1'($urandom)}, 32'h0, acc_id_t'(i));
      end else begin
        accel_op(tgt, acc_id_t'(i), $urandom);
      end
    end
    wait_idle();
    rand_ready = 1'b0;
  endtask

  task automatic test_data_routing();
    addr_t addrs [12];
    rand_ready = 1'b1;
    for (int i = 0; i < 12; i++) begin
      addrs[i] = ((i % 2) ? TcdmBase : 32'h8000_0000) | (($urandom % 16) << 12) | (i << 2);
    end
    // Just above the window goes to SoC
    addrs[11] = TcdmBase + (32'h1 << `CC_TCDM_ADDR_WIDTH) + (11 << 2);
    for (int i = 0; i < 6; i++) data_op(1'b1, addrs[i], $urandom);
    for (int i = 0; i < 12; i++) data_op(1'b0, addrs[i], '0);
    wait_idle();
    rand_ready = 1'b0;
  endtask

  initial begin
    void'($urandom(24));
    checks         = 0;
    errors         = 0;
    outstanding    = 0;
    rand_ready     = 1'b0;
    rst_ni         = 1'b1;
    tcdm_base_i    = TcdmBase;
    core_req_i     = '0;
    core_q_valid_i = 1'b0;
    core_p_ready_i = 1'b1;
    data_req_i     = '0;
    data_q_valid_i = 1'b0;
    data_p_ready_i = 1'b1;
    for (int i = 0; i < 16; i++) cfg_model[i / 8][i % 8] = '0;
    for (int i = 0; i < 1024; i++) begin
      shadow[0][i] = 32'(i) * 32'h9E37_79B9;
      shadow[1][i] = (32'(i) * 32'h9E37_79B9) ^ SaltTcdm;
    end
    repeat (16) @(posedge clk_i);
    #10;
    test_reset_quiet();
    rst_ni = 1'b0;
    @(posedge clk_i);
    #10;
    test_reset_quiet();
    test_accel_routing();
    test_ssr_config();
    test_offload_stress();
    test_data_routing();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+hw
hw/cc_pkg.sv
hw/offload_switch.sv
hw/ssr_cfg_unit.sv
hw/data_router.sv
hw/core_complex_top.sv
bench/cc_checker.sv
bench/cc_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module cc_tb -o cc_sim
	./obj_dir/cc_sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log
	! grep -q "TESTBENCH FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
